// File: Bender.yml
package:
  name: riscv_mext

sources:
  # packages first, the blocks import them.
  - files:
      - rtl/riscv_mext_pkg.sv
      - rtl/riscv_wb_pkg.sv
  - files:
      - rtl/riscv_multiplier.sv
      - rtl/riscv_divider.sv
      - rtl/riscv_mext_ctrl.sv
      - rtl/riscv_mext_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/riscv_mext_tb.sv

// File: files.f
+incdir+sim
rtl/riscv_mext_pkg.sv
rtl/riscv_wb_pkg.sv
rtl/riscv_multiplier.sv
rtl/riscv_divider.sv
rtl/riscv_mext_ctrl.sv
rtl/riscv_mext_top.sv
sim/riscv_mext_tb.sv

// File: rtl/riscv_divider.sv
`timescale 1ns/100ps

module riscv_divider #(
    parameter int XLEN = 64
) (
    input  logic                    i_riscv_clk,
    input  logic                    i_rst_n,
    input  logic                    i_riscv_div_start,
    input  riscv_mext_pkg::div_op_e i_riscv_div_divctrl,
    input  logic [XLEN-1:0]         i_riscv_div_rs1data,
    input  logic [XLEN-1:0]         i_riscv_div_rs2data,
    output logic                    o_riscv_div_done,
    output logic [XLEN-1:0]         o_riscv_div_result
);
    import riscv_mext_pkg::*;

    localparam int              CNT_W   = $clog2(XLEN);
    localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

    logic             op_signed;
    logic             rs1_neg;
    logic             rs2_neg;
    logic [XLEN-1:0]  rs1_mag;
    logic [XLEN-1:0]  rs2_mag;

    logic             busy_q;
    logic             done_q;
    logic [CNT_W-1:0] cnt_q;
    logic [XLEN-1:0]  rem_q;
    logic [XLEN-1:0]  quo_q;       // dividend bits shift out as quotient bits shift in.
    logic [XLEN-1:0]  dvs_q;
    logic             want_rem_q;
    logic             quo_neg_q;
    logic             rem_neg_q;
    logic             div_zero_q;
    logic             ovf_q;
    logic [XLEN-1:0]  result_q;

    logic [XLEN:0]    rem_shift;
    logic [XLEN:0]    trial;
    logic             q_bit;
    logic [XLEN-1:0]  rem_nx;
    logic [XLEN-1:0]  quo_nx;
    logic             last_iter;
    logic [XLEN-1:0]  final_val;

    assign op_signed = (i_riscv_div_divctrl == DIV_S) || (i_riscv_div_divctrl == REM_S);
    assign rs1_neg   = op_signed && i_riscv_div_rs1data[XLEN-1];
    assign rs2_neg   = op_signed && i_riscv_div_rs2data[XLEN-1];
    assign rs1_mag   = rs1_neg ? (~i_riscv_div_rs1data + XLEN'(1)) : i_riscv_div_rs1data;
    assign rs2_mag   = rs2_neg ? (~i_riscv_div_rs2data + XLEN'(1)) : i_riscv_div_rs2data;

    // one restoring step.
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign trial     = rem_shift - {1'b0, dvs_q};
    assign q_bit     = ~trial[XLEN];                    // no borrow, subtract sticks.
    assign rem_nx    = q_bit ? trial[XLEN-1:0] : rem_shift[XLEN-1:0];
    assign quo_nx    = {quo_q[XLEN-2:0], q_bit};
    assign last_iter = busy_q && (cnt_q == CNT_W'(XLEN-1));

    always_comb
    begin
        if (div_zero_q && !want_rem_q)
            final_val = '1;
        else if (ovf_q)
            final_val = want_rem_q ? '0 : MIN_NEG;
        else if (want_rem_q)
            final_val = rem_neg_q ? (~rem_nx + XLEN'(1)) : rem_nx;  // x/0 gives x back here.
        else
            final_val = quo_neg_q ? (~quo_nx + XLEN'(1)) : quo_nx;
    end

    always_ff @(posedge i_riscv_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            busy_q <= 1'b0;
            done_q <= 1'b0;
            cnt_q  <= '0;
        end
        else
        begin
            done_q <= last_iter && !i_riscv_div_start;
            if (i_riscv_div_start)
            begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end
            else if (busy_q)
            begin
                cnt_q <= cnt_q + 1'b1;
                if (last_iter)
                    busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_riscv_clk)
    begin
        if (i_riscv_div_start)
        begin
            rem_q      <= '0;
            quo_q      <= rs1_mag;
            dvs_q      <= rs2_mag;
            want_rem_q <= (i_riscv_div_divctrl == REM_S) || (i_riscv_div_divctrl == REM_U);
            quo_neg_q  <= rs1_neg ^ rs2_neg;
            rem_neg_q  <= rs1_neg;                      // remainder takes the dividend sign.
            div_zero_q <= (i_riscv_div_rs2data == '0);
            ovf_q      <= op_signed && (i_riscv_div_rs1data == MIN_NEG) &&
                          (i_riscv_div_rs2data == '1);
        end
        else if (busy_q)
        begin
            rem_q <= rem_nx;
            quo_q <= quo_nx;
            if (last_iter)
                result_q <= final_val;
        end
    end

    assign o_riscv_div_done   = done_q;
    assign o_riscv_div_result = result_q;

endmodule

// File: rtl/riscv_mext_ctrl.sv
`timescale 1ns/100ps

module riscv_mext_ctrl #(
    parameter int XLEN = 64
) (
    input  logic                    i_riscv_clk,
    input  logic                    i_rst_n,
    input  riscv_wb_pkg::wb_req_t   i_wb_req,
    output riscv_wb_pkg::wb_rsp_t   o_wb_rsp,
    output logic [XLEN-1:0]         o_mul_rs1,
    output logic [XLEN-1:0]         o_mul_rs2,
    output riscv_mext_pkg::mul_op_e o_mul_ctrl,
    input  logic [XLEN-1:0]         i_mul_product,
    output logic                    o_div_start,
    output riscv_mext_pkg::div_op_e o_div_ctrl,
    output logic [XLEN-1:0]         o_div_rs1,
    output logic [XLEN-1:0]         o_div_rs2,
    input  logic                    i_div_done,
    input  logic [XLEN-1:0]         i_div_result
);
    import riscv_mext_pkg::*;
    import riscv_wb_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        MUL,
        DIV_WAIT
    } state_e;

    state_e           state_q;
    logic             req_valid;
    logic             wb_acc;
    logic             wb_hold_q;
    logic             ack_q;
    logic [WB_DW-1:0] rdata_d;
    logic [WB_DW-1:0] rdata_q;
    logic             op_wr;
    logic             op_go;
    mext_op_e         new_op;
    mext_op_e         op_q;
    logic [XLEN-1:0]  rs1_q;
    logic [XLEN-1:0]  rs2_q;
    logic [XLEN-1:0]  result_q;
    logic             busy_q;
    logic             done_q;
    logic             start_q;

    // accept once per strobe, the host has to drop stb before the next access.
    assign req_valid = i_wb_req.cyc && i_wb_req.stb;
    assign wb_acc    = req_valid && !wb_hold_q;
    assign op_wr     = wb_acc && i_wb_req.we && (i_wb_req.adr == REG_OP);
    assign new_op    = mext_op_e'(i_wb_req.dat[2:0]);
    assign op_go     = op_wr && (state_q == IDLE);      // dropped while busy.

    always_comb
    begin
        rdata_d = '0;
        case (i_wb_req.adr)
            REG_RS1:    rdata_d = WB_DW'(rs1_q);
            REG_RS2:    rdata_d = WB_DW'(rs2_q);
            REG_OP:     rdata_d = WB_DW'(op_q);
            REG_STATUS:
            begin
                rdata_d[STATUS_BUSY] = busy_q;
                rdata_d[STATUS_DONE] = done_q;
            end
            REG_RESULT: rdata_d = WB_DW'(result_q);
            default:    rdata_d = '0;
        endcase
    end

    always_ff @(posedge i_riscv_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            state_q   <= IDLE;
            wb_hold_q <= 1'b0;
            ack_q     <= 1'b0;
            busy_q    <= 1'b0;
            done_q    <= 1'b0;
            start_q   <= 1'b0;
            result_q  <= '0;
        end
        else
        begin
            wb_hold_q <= req_valid && (wb_hold_q || wb_acc);
            ack_q     <= wb_acc;
            start_q   <= 1'b0;
            case (state_q)
                IDLE:
                begin
                    if (op_go)
                    begin
                        busy_q  <= 1'b1;
                        done_q  <= 1'b0;
                        start_q <= is_div_op(new_op);
                        state_q <= is_div_op(new_op) ? DIV_WAIT : MUL;
                    end
                end
                MUL:
                begin
                    result_q <= i_mul_product;          // settles within the cycle.
                    busy_q   <= 1'b0;
                    done_q   <= 1'b1;
                    state_q  <= IDLE;
                end
                DIV_WAIT:
                begin
                    if (i_div_done)
                    begin
                        result_q <= i_div_result;
                        busy_q   <= 1'b0;
                        done_q   <= 1'b1;
                        state_q  <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge i_riscv_clk)
    begin
        if (wb_acc)
        begin
            rdata_q <= rdata_d;
            if (i_wb_req.we && (i_wb_req.adr == REG_RS1))
                rs1_q <= i_wb_req.dat[XLEN-1:0];
            if (i_wb_req.we && (i_wb_req.adr == REG_RS2))
                rs2_q <= i_wb_req.dat[XLEN-1:0];
        end
        if (op_go)
            op_q <= new_op;
    end

    assign o_wb_rsp    = '{dat: rdata_q, ack: ack_q};
    assign o_mul_rs1   = rs1_q;
    assign o_mul_rs2   = rs2_q;
    assign o_mul_ctrl  = to_mul_op(op_q);
    assign o_div_start = start_q;
    assign o_div_ctrl  = to_div_op(op_q);
    assign o_div_rs1   = rs1_q;
    assign o_div_rs2   = rs2_q;

endmodule

// File: rtl/riscv_mext_pkg.sv
package riscv_mext_pkg;

    // funct3 encoding of the M extension.
    typedef enum logic [2:0] {
        MUL    = 3'b000,
        MULH   = 3'b001,
        MULHSU = 3'b010,
        MULHU  = 3'b011,
        DIV    = 3'b100,
        DIVU   = 3'b101,
        REM    = 3'b110,
        REMU   = 3'b111
    } mext_op_e;

    typedef enum logic [1:0] {
        MUL_LO  = 2'b00,    // low half of the product.
        MULH_SS = 2'b01,
        MULH_SU = 2'b10,
        MULH_UU = 2'b11
    } mul_op_e;

    typedef enum logic [1:0] {
        DIV_S = 2'b00,
        DIV_U = 2'b01,
        REM_S = 2'b10,
        REM_U = 2'b11
    } div_op_e;

    function automatic logic is_div_op(mext_op_e op);
        return op[2];       // upper half of funct3 is the divide class.
    endfunction

    // low two funct3 bits pick the variant inside each class.
    function automatic mul_op_e to_mul_op(mext_op_e op);
        return mul_op_e'(op[1:0]);
    endfunction

    function automatic div_op_e to_div_op(mext_op_e op);
        return div_op_e'(op[1:0]);
    endfunction

endpackage

// File: rtl/riscv_mext_top.sv
`timescale 1ns/100ps

module riscv_mext_top #(
    parameter int XLEN = 64
) (
    input  logic                  i_riscv_clk,
    input  logic                  i_rst_n,
    input  riscv_wb_pkg::wb_req_t i_wb_req,
    output riscv_wb_pkg::wb_rsp_t o_wb_rsp
);
    import riscv_mext_pkg::*;

    logic [XLEN-1:0] mul_rs1;
    logic [XLEN-1:0] mul_rs2;
    mul_op_e         mul_ctrl;
    logic [XLEN-1:0] mul_product;
    logic            div_start;
    div_op_e         div_ctrl;
    logic [XLEN-1:0] div_rs1;
    logic [XLEN-1:0] div_rs2;
    logic            div_done;
    logic [XLEN-1:0] div_result;

    riscv_mext_ctrl #(
        .XLEN(XLEN)
    ) u_ctrl (
        .i_riscv_clk  (i_riscv_clk),
        .i_rst_n      (i_rst_n),
        .i_wb_req     (i_wb_req),
        .o_wb_rsp     (o_wb_rsp),
        .o_mul_rs1    (mul_rs1),
        .o_mul_rs2    (mul_rs2),
        .o_mul_ctrl   (mul_ctrl),
        .i_mul_product(mul_product),
        .o_div_start  (div_start),
        .o_div_ctrl   (div_ctrl),
        .o_div_rs1    (div_rs1),
        .o_div_rs2    (div_rs2),
        .i_div_done   (div_done),
        .i_div_result (div_result)
    );

    riscv_multiplier #(
        .XLEN(XLEN)
    ) u_mul (
        .i_riscv_mul_rs1data(mul_rs1),
        .i_riscv_mul_rs2data(mul_rs2),
        .i_riscv_mul_mulctrl(mul_ctrl),
        .o_riscv_mul_product(mul_product)
    );

    riscv_divider #(
        .XLEN(XLEN)
    ) u_div (
        .i_riscv_clk        (i_riscv_clk),
        .i_rst_n            (i_rst_n),
        .i_riscv_div_start  (div_start),
        .i_riscv_div_divctrl(div_ctrl),
        .i_riscv_div_rs1data(div_rs1),
        .i_riscv_div_rs2data(div_rs2),
        .o_riscv_div_done   (div_done),
        .o_riscv_div_result (div_result)
    );

endmodule

// File: rtl/riscv_multiplier.sv
`timescale 1ns/100ps

module riscv_multiplier #(
    parameter int XLEN = 64
) (
    input  logic [XLEN-1:0]         i_riscv_mul_rs1data,
    input  logic [XLEN-1:0]         i_riscv_mul_rs2data,
    input  riscv_mext_pkg::mul_op_e i_riscv_mul_mulctrl,
    output logic [XLEN-1:0]         o_riscv_mul_product
);
    import riscv_mext_pkg::*;

    logic              rs1_signed;
    logic              rs2_signed;
    logic              rs1_neg;
    logic              rs2_neg;
    logic [XLEN-1:0]   rs1_mag;
    logic [XLEN-1:0]   rs2_mag;
    logic [2*XLEN-1:0] mag_product;
    logic [2*XLEN-1:0] product;

    // MUL_LO counts as signed; its low half comes out the same anyway.
    assign rs1_signed = (i_riscv_mul_mulctrl != MULH_UU);
    assign rs2_signed = (i_riscv_mul_mulctrl == MUL_LO) ||
                        (i_riscv_mul_mulctrl == MULH_SS);

    assign rs1_neg = rs1_signed && i_riscv_mul_rs1data[XLEN-1];
    assign rs2_neg = rs2_signed && i_riscv_mul_rs2data[XLEN-1];

    // magnitudes, most negative value maps onto itself as unsigned.
    assign rs1_mag = rs1_neg ? (~i_riscv_mul_rs1data + XLEN'(1)) : i_riscv_mul_rs1data;
    assign rs2_mag = rs2_neg ? (~i_riscv_mul_rs2data + XLEN'(1)) : i_riscv_mul_rs2data;

    // unsigned shift-add over the multiplier bits.
    always_comb
    begin
        mag_product = '0;
        for (int i = 0; i < XLEN; i++)
        begin
            if (rs2_mag[i])
            begin
                mag_product = mag_product + ({{XLEN{1'b0}}, rs1_mag} << i);
            end
        end
    end

    // sign of the result is the xor of the operand signs.
    assign product = (rs1_neg ^ rs2_neg) ? (~mag_product + (2*XLEN)'(1)) : mag_product;

    assign o_riscv_mul_product = (i_riscv_mul_mulctrl == MUL_LO) ? product[XLEN-1:0]
                                                                 : product[2*XLEN-1:XLEN];

endmodule

// File: rtl/riscv_wb_pkg.sv
package riscv_wb_pkg;

    localparam int WB_DW = 64;
    localparam int WB_AW = 3;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;  // register index, not a byte address.
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic [WB_DW-1:0] dat;
        logic             ack;
    } wb_rsp_t;

    // register map.
    localparam logic [WB_AW-1:0] REG_RS1    = 3'd0;
    localparam logic [WB_AW-1:0] REG_RS2    = 3'd1;
    localparam logic [WB_AW-1:0] REG_OP     = 3'd2;    // write starts the operation.
    localparam logic [WB_AW-1:0] REG_STATUS = 3'd3;
    localparam logic [WB_AW-1:0] REG_RESULT = 3'd4;

    // status register bits.
    localparam int STATUS_BUSY = 0;
    localparam int STATUS_DONE = 1;

endpackage

// File: sim/riscv_mext_ref.svh
`ifndef RISCV_MEXT_REF_SVH
`define RISCV_MEXT_REF_SVH

// model functions sized by the XLEN of the including module.

function automatic logic [XLEN-1:0] product_half(logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                                                 logic a_signed, logic b_signed,
                                                 logic high);
    logic [2*XLEN-1:0] ea;
    logic [2*XLEN-1:0] eb;
    logic [2*XLEN-1:0] prod;
    ea   = a_signed ? {{XLEN{a[XLEN-1]}}, a} : {{XLEN{1'b0}}, a};
    eb   = b_signed ? {{XLEN{b[XLEN-1]}}, b} : {{XLEN{1'b0}}, b};
    prod = ea * eb;     // extended operands keep the wrapped product exact.
    return high ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];
endfunction

function automatic logic [XLEN-1:0] div_or_rem(logic [XLEN-1:0] a, logic [XLEN-1:0] b,
                                               logic is_signed, logic want_rem);
    logic [XLEN-1:0] min_neg;
    logic [XLEN-1:0] quo;
    logic [XLEN-1:0] rem;
    min_neg = {1'b1, {(XLEN-1){1'b0}}};
    if (b == '0)
        return want_rem ? a : '1;
    if (is_signed && (a == min_neg) && (b == '1))
        return want_rem ? '0 : min_neg;
    if (is_signed)
    begin
        quo = $signed(a) / $signed(b);
        rem = $signed(a) % $signed(b);      // truncates toward zero.
    end
    else
    begin
        quo = a / b;
        rem = a % b;
    end
    return want_rem ? rem : quo;
endfunction

function automatic logic [XLEN-1:0] expected_result(riscv_mext_pkg::mext_op_e op,
                                                    logic [XLEN-1:0] a, logic [XLEN-1:0] b);
    case (op)
        riscv_mext_pkg::MUL:    return product_half(a, b, 1'b1, 1'b1, 1'b0);
        riscv_mext_pkg::MULH:   return product_half(a, b, 1'b1, 1'b1, 1'b1);
        riscv_mext_pkg::MULHSU: return product_half(a, b, 1'b1, 1'b0, 1'b1);
        riscv_mext_pkg::MULHU:  return product_half(a, b, 1'b0, 1'b0, 1'b1);
        riscv_mext_pkg::DIV:    return div_or_rem(a, b, 1'b1, 1'b0);
        riscv_mext_pkg::DIVU:   return div_or_rem(a, b, 1'b0, 1'b0);
        riscv_mext_pkg::REM:    return div_or_rem(a, b, 1'b1, 1'b1);
        riscv_mext_pkg::REMU:   return div_or_rem(a, b, 1'b0, 1'b1);
        default:                return '0;
    endcase
endfunction

`endif

// File: sim/riscv_mext_tb.sv
`timescale 1ns/100ps

module riscv_mext_tb;
    import riscv_mext_pkg::*;
    import riscv_wb_pkg::*;

    localparam int XLEN          = 64;
    localparam int CLK_PERIOD    = 10;
    localparam int ACK_LIMIT     = 4;
    localparam int POLL_LIMIT    = XLEN + 20;
    localparam int NUM_MUL_VALS  = 5;
    localparam int NUM_DIV_PAIRS = 12;
    localparam int NUM_RANDOM    = 200;
    // operations started by the tests plus the busy check.
    localparam int NUM_OPS       = NUM_MUL_VALS * NUM_MUL_VALS * 4 + NUM_DIV_PAIRS * 4
                                   + NUM_RANDOM + 1;
    localparam int RUN_CYCLES    = NUM_OPS * (XLEN + 20) + 1000;

    `include "riscv_mext_ref.svh"

    logic        clk;
    logic        rst_n;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    logic [63:0] lcg_state;

    riscv_mext_top #(
        .XLEN(XLEN)
    ) dut (
        .i_riscv_clk(clk),
        .i_rst_n    (rst_n),
        .i_wb_req   (wb_req),
        .o_wb_rsp   (wb_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic report_failure(input string why);
        $display("ERROR at %0t: %s", $time, why);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp)
        else
        begin
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic [63:0] lcg_next();
        lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
        return lcg_state;
    endfunction

    function automatic logic [XLEN-1:0] rand_word();
        logic [63:0] hi;
        logic [63:0] lo;
        hi = lcg_next();
        lo = lcg_next();
        return XLEN'({hi[63:32], lo[63:32]});   // upper lcg bits are the better ones.
    endfunction

    function automatic logic [XLEN-1:0] negate(input logic [XLEN-1:0] v);
        return ~v + 1'b1;
    endfunction

    // one classic cycle with a single-cycle ack.
    task automatic wb_access(input logic we, input logic [2:0] adr, input logic [63:0] wdat,
                             output logic [63:0] rdat);
        logic got_ack;
        got_ack    = 1'b0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        for (int i = 0; i < ACK_LIMIT && !got_ack; i++)
        begin
            @(posedge clk);
            #1;
            got_ack = wb_rsp.ack;
        end
        assert (got_ack)
        else
            report_failure($sformatf("no ack within %0d cycles at index %0d", ACK_LIMIT, adr));
        rdat   = wb_rsp.dat;
        wb_req = '0;
        @(posedge clk);
        #1;
        assert (!wb_rsp.ack)
        else
            report_failure($sformatf("ack held longer than one cycle at index %0d", adr));
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [63:0] wdat);
        logic [63:0] unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [63:0] rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    // status polling until done shows.
    task automatic wait_done(output int polls);
        logic [63:0] status;
        polls  = 0;
        status = '0;
        while (!status[STATUS_DONE] && polls < POLL_LIMIT)
        begin
            wb_read(REG_STATUS, status);
            polls++;
            if (!status[STATUS_DONE])
                check_value("status busy while running", status[STATUS_BUSY], 1'b1);
        end
        assert (status[STATUS_DONE])
        else
            report_failure("operation did not finish within the poll limit");
        check_value("status busy at done", status[STATUS_BUSY], 1'b0);
    endtask

    task automatic run_op(input mext_op_e op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, output logic [XLEN-1:0] res,
                          output int polls);
        logic [63:0] rd;
        wb_write(REG_RS1, 64'(a));
        wb_write(REG_RS2, 64'(b));
        wb_write(REG_OP, 64'(op));
        wait_done(polls);
        wb_read(REG_RESULT, rd);
        res = rd[XLEN-1:0];
    endtask

    task automatic check_op(input mext_op_e op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        logic [XLEN-1:0] res;
        logic [XLEN-1:0] exp;
        int              polls;
        exp = expected_result(op, a, b);
        run_op(op, a, b, res, polls);
        if (!op[2])
            check_value("status polls until multiply done", 64'(polls), 64'd1);
        check_value($sformatf("%s(%h, %h) result", op.name(), a, b), 64'(res), 64'(exp));
    endtask

    task automatic after_reset();
        logic [63:0] rd;
        wb_read(REG_STATUS, rd);
        check_value("status after reset", rd, 64'd0);
        wb_read(REG_RESULT, rd);
        check_value("result after reset", rd, 64'd0);
    endtask

    task automatic reg_readback();
        logic [XLEN-1:0] v1;
        logic [XLEN-1:0] v2;
        logic [63:0]     rd;
        v1 = rand_word();
        v2 = rand_word();
        wb_write(REG_RS1, 64'(v1));
        wb_write(REG_RS2, 64'(v2));
        wb_read(REG_RS1, rd);
        check_value("rs1 read-back", rd, 64'(v1));
        wb_read(REG_RS2, rd);
        check_value("rs2 read-back", rd, 64'(v2));
        for (int adr = 5; adr < 8; adr++)
        begin
            wb_read(3'(adr), rd);
            check_value($sformatf("unmapped index %0d", adr), rd, 64'd0);
        end
    endtask

    task automatic mul_corners();
        logic [XLEN-1:0] vals [NUM_MUL_VALS];
        vals[0] = '0;
        vals[1] = XLEN'(1);
        vals[2] = '1;                           // -1 and the all-ones pattern.
        vals[3] = {1'b1, {(XLEN-1){1'b0}}};
        vals[4] = {1'b0, {(XLEN-1){1'b1}}};
        for (int i = 0; i < NUM_MUL_VALS; i++)
            for (int j = 0; j < NUM_MUL_VALS; j++)
                for (int k = 0; k < 4; k++)
                    check_op(mext_op_e'(3'(k)), vals[i], vals[j]);
    endtask

    task automatic div_corners();
        logic [XLEN-1:0] da [NUM_DIV_PAIRS];
        logic [XLEN-1:0] db [NUM_DIV_PAIRS];
        logic [XLEN-1:0] min_neg;
        min_neg = {1'b1, {(XLEN-1){1'b0}}};
        da[0]  = XLEN'(20);
        db[0]  = XLEN'(6);
        da[1]  = negate(XLEN'(20));
        db[1]  = XLEN'(6);
        da[2]  = XLEN'(20);
        db[2]  = negate(XLEN'(6));
        da[3]  = negate(XLEN'(20));
        db[3]  = negate(XLEN'(6));
        da[4]  = XLEN'(7);
        db[4]  = '0;                  // divide by zero.
        da[5]  = negate(XLEN'(7));
        db[5]  = '0;
        da[6]  = min_neg;
        db[6]  = '1;                  // signed overflow.
        da[7]  = min_neg;
        db[7]  = XLEN'(1);
        da[8]  = '0;
        db[8]  = XLEN'(5);
        da[9]  = '1;
        db[9]  = XLEN'(2);
        da[10] = XLEN'(5);
        db[10] = XLEN'(20);
        da[11] = ~min_neg;
        db[11] = min_neg;
        for (int i = 0; i < NUM_DIV_PAIRS; i++)
            for (int k = 0; k < 4; k++)
                check_op(mext_op_e'(3'(4 + k)), da[i], db[i]);
    endtask

    task automatic random_ops();
        mext_op_e        op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [63:0]     r;
        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            r  = lcg_next();
            op = mext_op_e'(r[63:61]);
            a  = rand_word();
            b  = rand_word();
            if (op[2])
                b = b >> (r[47:40] % XLEN);     // smaller divisors give real quotients.
            check_op(op, a, b);
        end
    endtask

    // second op write lands while the divider runs.
    task automatic busy_protection();
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [63:0]     rd;
        int              polls;
        a = rand_word();
        b = XLEN'(3);
        wb_write(REG_RS1, 64'(a));
        wb_write(REG_RS2, 64'(b));
        wb_write(REG_OP, 64'(DIV));
        wb_write(REG_OP, 64'(MUL));
        wb_read(REG_STATUS, rd);
        check_value("status busy after ignored op write", rd[STATUS_BUSY], 1'b1);
        check_value("status done after ignored op write", rd[STATUS_DONE], 1'b0);
        wait_done(polls);
        wb_read(REG_RESULT, rd);
        check_value("result after ignored op write", rd, 64'(expected_result(DIV, a, b)));
    endtask

    initial
    begin
        #(RUN_CYCLES * CLK_PERIOD);
        report_failure($sformatf("watchdog expired after %0d cycles", RUN_CYCLES));
    end

    initial
    begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        wb_req    = '0;
        lcg_state = 64'd15500;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        after_reset();
        reg_readback();
        mul_corners();
        div_corners();
        random_ops();
        busy_protection();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
